/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := tb_axi_read_xbar
FILELIST  := axi_read_xbar.f
BUILD_DIR := obj_dir
LOG       := sim.log
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* axi_read_pkg.sv */
package axi_read_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] data_t;
    typedef logic [1:0]  resp_t;

    localparam resp_t RESP_OKAY   = 2'b00;
    localparam resp_t RESP_SLVERR = 2'b10;

    // Core-local timer window
    localparam addr_t CLINT_BASE = 32'h0200_0000;
    localparam addr_t CLINT_LAST = 32'h0200_0007;

    typedef enum logic {
        IDLE,
        BUSY
    } arb_state_t;

    // Target 0 is the timer, target 1 the external bus
    function automatic int unsigned decode_target(addr_t addr);
        if (addr >= CLINT_BASE && addr <= CLINT_LAST) begin
            return 0;
        end
        return 1;
    endfunction

endpackage

/* axi_read_xbar.f */
axi_read_pkg.sv
read_arbiter.sv
slave_read_port.sv
response_router.sv
axi_read_xbar.sv
tb_clock_gen.sv
tb_axi_read_xbar.sv

/* axi_read_xbar.sv */
`timescale 1ns/1ps

module axi_read_xbar import axi_read_pkg::*; #(
    parameter int NUM_MASTERS = 2,
    parameter int NUM_SLAVES  = 2
) (
    input  logic  clk,
    input  logic  reset,

    input  logic  m_arvalid [NUM_MASTERS],
    input  addr_t m_araddr  [NUM_MASTERS],
    output logic  m_arready [NUM_MASTERS],
    output logic  m_rvalid  [NUM_MASTERS],
    output data_t m_rdata   [NUM_MASTERS],
    output resp_t m_rresp   [NUM_MASTERS],
    input  logic  m_rready  [NUM_MASTERS],

    output logic  s_arvalid [NUM_SLAVES],
    output addr_t s_araddr  [NUM_SLAVES],
    input  logic  s_arready [NUM_SLAVES],
    input  logic  s_rvalid  [NUM_SLAVES],
    input  data_t s_rdata   [NUM_SLAVES],
    input  resp_t s_rresp   [NUM_SLAVES],
    output logic  s_rready  [NUM_SLAVES]
);

    localparam int MIDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1;
    localparam int SIDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1;

    logic [NUM_SLAVES-1:0] start;
    addr_t                 start_addr;
    logic [MIDX_W-1:0]     grant_master;
    logic [SIDX_W-1:0]     grant_slave;
    logic                  busy;
    logic                  done;

    read_arbiter #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES)
    ) i_arbiter (
        .clk          (clk),
        .reset        (reset),
        .m_arvalid    (m_arvalid),
        .m_araddr     (m_araddr),
        .done         (done),
        .m_arready    (m_arready),
        .start        (start),
        .start_addr   (start_addr),
        .grant_master (grant_master),
        .grant_slave  (grant_slave),
        .busy         (busy)
    );

    for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_slave_port
        slave_read_port i_port (
            .clk        (clk),
            .reset      (reset),
            .start      (start[i]),
            .start_addr (start_addr),
            .s_arready  (s_arready[i]),
            .s_arvalid  (s_arvalid[i]),
            .s_araddr   (s_araddr[i])
        );
    end

    response_router #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES)
    ) i_router (
        .busy         (busy),
        .grant_master (grant_master),
        .grant_slave  (grant_slave),
        .s_rvalid     (s_rvalid),
        .s_rdata      (s_rdata),
        .s_rresp      (s_rresp),
        .m_rready     (m_rready),
        .m_rvalid     (m_rvalid),
        .m_rdata      (m_rdata),
        .m_rresp      (m_rresp),
        .s_rready     (s_rready),
        .done         (done)
    );

endmodule

/* read_arbiter.sv */
`timescale 1ns/1ps

module read_arbiter import axi_read_pkg::*; #(
    parameter int NUM_MASTERS = 2,
    parameter int NUM_SLAVES  = 2,
    localparam int MIDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1,
    localparam int SIDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  m_arvalid [NUM_MASTERS],
    input  addr_t                 m_araddr  [NUM_MASTERS],
    input  logic                  done,
    output logic                  m_arready [NUM_MASTERS],
    output logic [NUM_SLAVES-1:0] start,
    output addr_t                 start_addr,
    output logic [MIDX_W-1:0]     grant_master,
    output logic [SIDX_W-1:0]     grant_slave,
    output logic                  busy
);

    arb_state_t        state;
    logic              req_any;
    logic [MIDX_W-1:0] pick;
    logic [SIDX_W-1:0] target;
    logic              ack;

    // Lowest index wins, so scan downwards and let the last hit stand
    always_comb begin
        req_any = 1'b0;
        pick    = '0;
        for (int i = NUM_MASTERS - 1; i >= 0; i--) begin
            if (m_arvalid[i]) begin
                req_any = 1'b1;
                pick    = MIDX_W'(i);
            end
        end
    end

    assign start_addr = m_araddr[pick];
    assign target     = SIDX_W'(decode_target(start_addr));
    assign ack        = (state == IDLE) && req_any;
    assign busy       = (state == BUSY);

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            m_arready[i] = ack && (pick == MIDX_W'(i)); // AR accepted in the request cycle
        end
    end

    always_comb begin
        for (int s = 0; s < NUM_SLAVES; s++) begin
            start[s] = ack && (target == SIDX_W'(s)); // One-hot load pulse
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            grant_master <= '0;
            grant_slave  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (req_any) begin
                        state        <= BUSY;
                        grant_master <= pick;
                        grant_slave  <= target;
                    end
                end
                BUSY: begin
                    if (done) begin
                        state <= IDLE; // Free again the cycle after R handshake
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

endmodule

/* response_router.sv */
`timescale 1ns/1ps

module response_router import axi_read_pkg::*; #(
    parameter int NUM_MASTERS = 2,
    parameter int NUM_SLAVES  = 2,
    localparam int MIDX_W = (NUM_MASTERS > 1) ? $clog2(NUM_MASTERS) : 1,
    localparam int SIDX_W = (NUM_SLAVES > 1) ? $clog2(NUM_SLAVES) : 1
) (
    input  logic              busy,
    input  logic [MIDX_W-1:0] grant_master,
    input  logic [SIDX_W-1:0] grant_slave,
    input  logic              s_rvalid [NUM_SLAVES],
    input  data_t             s_rdata  [NUM_SLAVES],
    input  resp_t             s_rresp  [NUM_SLAVES],
    input  logic              m_rready [NUM_MASTERS],
    output logic              m_rvalid [NUM_MASTERS],
    output data_t             m_rdata  [NUM_MASTERS],
    output resp_t             m_rresp  [NUM_MASTERS],
    output logic              s_rready [NUM_SLAVES],
    output logic              done
);

    always_comb begin
        for (int i = 0; i < NUM_MASTERS; i++) begin
            m_rvalid[i] = 1'b0;
            m_rdata[i]  = '0;
            m_rresp[i]  = RESP_OKAY;
        end
        for (int s = 0; s < NUM_SLAVES; s++) begin
            s_rready[s] = 1'b0;
        end
        done = 1'b0;

        // Only the granted pair is connected
        if (busy) begin
            m_rvalid[grant_master] = s_rvalid[grant_slave];
            m_rdata[grant_master]  = s_rdata[grant_slave];
            m_rresp[grant_master]  = s_rresp[grant_slave];
            s_rready[grant_slave]  = m_rready[grant_master];
            done = s_rvalid[grant_slave] && m_rready[grant_master]; // R handshake
        end
    end

endmodule

/* slave_read_port.sv */
`timescale 1ns/1ps

module slave_read_port import axi_read_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  start,
    input  addr_t start_addr,
    input  logic  s_arready,
    output logic  s_arvalid,
    output addr_t s_araddr
);

    logic ar_fire;

    assign ar_fire = s_arvalid && s_arready;

    // Address is held stable until the target takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            s_arvalid <= 1'b0;
            s_araddr  <= '0;
        end else if (start) begin
            s_arvalid <= 1'b1;
            s_araddr  <= start_addr;
        end else if (ar_fire) begin
            s_arvalid <= 1'b0;
            s_araddr  <= '0; // Quiet bus between requests
        end
    end

endmodule

/* tb_axi_read_xbar.sv */
`timescale 1ns/1ps

module tb_axi_read_xbar import axi_read_pkg::*; ();

    localparam int NUM_MASTERS    = 2;
    localparam int NUM_SLAVES     = 2;
    localparam int NUM_DIRECTED   = 6;
    localparam int NUM_RANDOM     = 40;
    localparam int TOTAL_READS    = NUM_MASTERS * (NUM_DIRECTED + NUM_RANDOM);
    localparam int TIMEOUT_CYCLES = 100 * 12; // 12 cycles per read, 100 reads

    localparam data_t SLAVE_TAG [NUM_SLAVES] = '{32'h7100_0000, 32'h0E00_0000};
    localparam addr_t DIRECTED [NUM_DIRECTED] = '{
        32'h0200_0000, 32'h0200_0007, 32'h0200_0008,
        32'h01FF_FFFC, 32'h0200_0004, 32'h8000_0004
    };

    logic  clk;
    logic  reset;
    logic  m_arvalid [NUM_MASTERS];
    addr_t m_araddr  [NUM_MASTERS];
    logic  m_arready [NUM_MASTERS];
    logic  m_rvalid  [NUM_MASTERS];
    data_t m_rdata   [NUM_MASTERS];
    resp_t m_rresp   [NUM_MASTERS];
    logic  m_rready  [NUM_MASTERS];
    logic  s_arvalid [NUM_SLAVES];
    addr_t s_araddr  [NUM_SLAVES];
    logic  s_arready [NUM_SLAVES];
    logic  s_rvalid  [NUM_SLAVES];
    data_t s_rdata   [NUM_SLAVES];
    resp_t s_rresp   [NUM_SLAVES];
    logic  s_rready  [NUM_SLAVES];

    integer seed       = 32'h8ae6b254;
    int     errors     = 0;
    int     reads_done = 0;
    int     cycle      = 0;

    logic  in_flight     = 1'b0;
    logic  first_after   = 1'b0;
    int    flight_master = 0;
    int    flight_slave  = 0;
    addr_t flight_addr   = '0;
    logic  outstanding [NUM_MASTERS];
    addr_t sent_addr   [NUM_MASTERS];
    logic  held_valid  [NUM_MASTERS];
    data_t held_data   [NUM_MASTERS];
    resp_t held_resp   [NUM_MASTERS];

    tb_clock_gen #(
        .HALF_PERIOD  (2),
        .RESET_CYCLES (2)
    ) i_clock_gen (
        .clk   (clk),
        .reset (reset)
    );

    axi_read_xbar #(
        .NUM_MASTERS (NUM_MASTERS),
        .NUM_SLAVES  (NUM_SLAVES)
    ) i_dut (
        .clk       (clk),
        .reset     (reset),
        .m_arvalid (m_arvalid),
        .m_araddr  (m_araddr),
        .m_arready (m_arready),
        .m_rvalid  (m_rvalid),
        .m_rdata   (m_rdata),
        .m_rresp   (m_rresp),
        .m_rready  (m_rready),
        .s_arvalid (s_arvalid),
        .s_araddr  (s_araddr),
        .s_arready (s_arready),
        .s_rvalid  (s_rvalid),
        .s_rdata   (s_rdata),
        .s_rresp   (s_rresp),
        .s_rready  (s_rready)
    );

    // Timer window reads come back with tag 0, all else with tag 1
    function automatic void expected_read(input addr_t addr, output data_t data,
                                          output resp_t resp);
        int unsigned target;
        target = decode_target(addr);
        if (target == 0) begin
            data = addr ^ 32'h7100_0000;
            resp = RESP_OKAY;
        end else begin
            data = addr ^ 32'h0E00_0000;
            resp = addr[2] ? RESP_SLVERR : RESP_OKAY;
        end
    endfunction

    function automatic addr_t random_addr();
        if ($random(seed) & 1) begin
            return CLINT_BASE - 32'd16 + ($unsigned($random(seed)) % 32'd40); // Around the window
        end
        return $random(seed);
    endfunction

    task automatic compare_value(input string name, input int idx,
                                 input logic [31:0] actual, input logic [31:0] expected);
        assert (actual === expected) else begin
            errors++;
            $display("[FAIL] %0t %s[%0d] expected %h got %h", $time, name, idx, expected, actual);
        end
    endtask

    for (genvar m = 0; m < NUM_MASTERS; m++) begin : g_master
        logic  arvalid = 1'b0;
        addr_t araddr  = '0;
        logic  rready  = 1'b0;

        assign m_arvalid[m] = arvalid;
        assign m_araddr[m]  = araddr;
        assign m_rready[m]  = rready;

        initial begin
            int unsigned delay;
            @(posedge clk);
            while (reset) @(posedge clk);
            for (int k = 0; k < NUM_DIRECTED + NUM_RANDOM; k++) begin
                arvalid <= 1'b1;
                if (k < NUM_DIRECTED) begin
                    araddr <= DIRECTED[k]; // Both masters start together
                end else begin
                    araddr <= random_addr();
                end
                @(posedge clk);
                while (!m_arready[m]) @(posedge clk);
                arvalid <= 1'b0;
                araddr  <= '0;
                @(posedge clk);
                while (!m_rvalid[m]) @(posedge clk);
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                rready <= 1'b1;
                @(posedge clk);
                while (!m_rvalid[m]) @(posedge clk); // rvalid is held, so this is the handshake
                rready <= 1'b0;
                delay = $unsigned($random(seed)) % 3;
                repeat (delay) @(posedge clk);
            end
        end
    end

    for (genvar j = 0; j < NUM_SLAVES; j++) begin : g_slave
        logic  arready = 1'b0;
        logic  rvalid  = 1'b0;
        data_t rdata   = '0;
        resp_t rresp   = RESP_OKAY;

        assign s_arready[j] = arready;
        assign s_rvalid[j]  = rvalid;
        assign s_rdata[j]   = rdata;
        assign s_rresp[j]   = rresp;

        initial begin
            int unsigned delay;
            addr_t       addr;
            @(posedge clk);
            while (reset) @(posedge clk);
            forever begin
                @(posedge clk);
                while (!s_arvalid[j]) @(posedge clk);
                delay = $unsigned($random(seed)) % 3;
                repeat (delay) @(posedge clk);
                arready <= 1'b1;
                @(posedge clk);
                addr = s_araddr[j]; // AR handshake edge
                arready <= 1'b0;
                delay = $unsigned($random(seed)) % 4;
                repeat (delay) @(posedge clk);
                rvalid <= 1'b1;
                rdata  <= addr ^ SLAVE_TAG[j];
                rresp  <= (j == 1 && addr[2]) ? RESP_SLVERR : RESP_OKAY;
                @(posedge clk);
                while (!s_rready[j]) @(posedge clk);
                rvalid <= 1'b0;
                rdata  <= '0;
                rresp  <= RESP_OKAY;
            end
        end
    end

    always @(posedge clk) begin
        data_t exp_data;
        resp_t exp_resp;
        logic  first_req;
        int    ar_count;
        cycle++;
        if (cycle > 1) begin
            if (reset || first_after) begin
                for (int i = 0; i < NUM_MASTERS; i++) begin
                    compare_value("m_arready", i, 32'(m_arready[i]), 32'd0);
                    compare_value("m_rvalid", i, 32'(m_rvalid[i]), 32'd0);
                end
                for (int s = 0; s < NUM_SLAVES; s++) begin
                    compare_value("s_arvalid", s, 32'(s_arvalid[s]), 32'd0);
                    compare_value("s_rready", s, 32'(s_rready[s]), 32'd0);
                end
            end
            first_req = 1'b1;
            ar_count  = 0;
            for (int i = 0; i < NUM_MASTERS; i++) begin
                compare_value("m_arready", i, 32'(m_arready[i]),
                              32'(!in_flight && m_arvalid[i] && first_req)); // Lowest index wins
                if (m_arvalid[i]) begin
                    first_req = 1'b0;
                end
            end
            for (int s = 0; s < NUM_SLAVES; s++) begin
                ar_count += int'(s_arvalid[s]);
                compare_value("s_araddr", s, s_araddr[s], s_arvalid[s] ? flight_addr : '0);
                compare_value("s_rready", s, 32'(s_rready[s]),
                              32'(in_flight && flight_slave == s
                                  && m_rready[flight_master])); // Only the target sees rready
            end
            assert (ar_count <= 1) else begin
                errors++;
                $display("Error at %0t: more than one slave sees s_arvalid high", $time);
            end
            for (int i = 0; i < NUM_MASTERS; i++) begin
                if (held_valid[i]) begin
                    compare_value("m_rvalid", i, 32'(m_rvalid[i]), 32'd1);
                    compare_value("m_rdata", i, m_rdata[i], held_data[i]);
                    compare_value("m_rresp", i, 32'(m_rresp[i]), 32'(held_resp[i]));
                end
                if (!outstanding[i]) begin
                    compare_value("m_rvalid", i, 32'(m_rvalid[i]), 32'd0);
                    compare_value("m_rdata", i, m_rdata[i], 32'd0);
                    compare_value("m_rresp", i, 32'(m_rresp[i]), 32'd0);
                end
                if (m_rvalid[i] && m_rready[i]) begin
                    expected_read(sent_addr[i], exp_data, exp_resp);
                    compare_value("m_rdata", i, m_rdata[i], exp_data);
                    compare_value("m_rresp", i, 32'(m_rresp[i]), 32'(exp_resp));
                    outstanding[i] = 1'b0;
                    in_flight      = 1'b0;
                    reads_done++;
                end
                if (m_arvalid[i] && m_arready[i]) begin
                    sent_addr[i]   = m_araddr[i];
                    outstanding[i] = 1'b1;
                    in_flight      = 1'b1;
                    flight_master  = i;
                    flight_addr    = m_araddr[i];
                    flight_slave   = int'(decode_target(m_araddr[i]));
                end
                held_valid[i] = m_rvalid[i] && !m_rready[i];
                held_data[i]  = m_rdata[i];
                held_resp[i]  = m_rresp[i];
            end
        end
        if (reset) begin
            in_flight = 1'b0;
            for (int i = 0; i < NUM_MASTERS; i++) begin
                outstanding[i] = 1'b0;
                held_valid[i]  = 1'b0;
            end
        end
        first_after = reset;
    end

    initial begin
        while (cycle < TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: only %0d of %0d reads finished after %0d cycles",
                 reads_done, TOTAL_READS, TIMEOUT_CYCLES);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        $timeformat(-9, 0, " ns", 0);
        while (reads_done < TOTAL_READS) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Reads checked: %0d of %0d, errors: %0d", reads_done, TOTAL_READS, errors);
        if (errors == 0 && reads_done == TOTAL_READS) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb_clock_gen.sv */
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 2,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    end

endmodule
